//--- hw/croc_bus_pkg.sv
// ------------------------------------------------------------------------
// Bus widths, address map and target indices for the bus domain.
// Single 32-bit word bus, no IDs and no grant. The SRAM and control
// regions must not overlap. Anything outside them goes to the error target.
// ------------------------------------------------------------------------
`default_nettype none

package croc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [8:0]  sram_addr_t;
  typedef logic [1:0]  target_idx_t;

  // ------------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------------
  localparam addr_t       SramBaseAddr  = 32'h1000_0000;
  localparam int unsigned SramNumWords  = 512;
  localparam addr_t       SramSizeBytes = 32'd2048;

  localparam addr_t       CtrlBaseAddr  = 32'h0300_0000;
  localparam addr_t       CtrlSizeBytes = 32'h0000_1000;

  // Target indices, code 3 is unused
  localparam target_idx_t TargetSram  = 2'd0;
  localparam target_idx_t TargetCtrl  = 2'd1;
  localparam target_idx_t TargetError = 2'd2;

  // Request edge to rvalid
  localparam int unsigned ReadLatency = 2;

endpackage

`default_nettype wire

//--- hw/croc_ctrl_pkg.sv
// ------------------------------------------------------------------------
// SoC control register map and error subordinate response.
// Offsets are byte offsets inside the 4 KiB control region. Only two
// registers exist; other offsets read as zero and ignore writes.
// ------------------------------------------------------------------------
`default_nettype none

package croc_ctrl_pkg;

  typedef logic [11:0] ctrl_off_t;

  // Register offsets
  localparam ctrl_off_t CtrlFetchEnOff  = 12'h000;
  localparam ctrl_off_t CtrlBootAddrOff = 12'h004;

  // Boot from the start of SRAM
  localparam logic [31:0] BootAddrReset = 32'h1000_0000;

  // Returned on any access to an unmapped address
  localparam logic [31:0] ErrRspData = 32'hBADC_AB1E;

endpackage

`default_nettype wire

//--- hw/bus_decoder.sv
// ------------------------------------------------------------------------
// Combinational address decoder.
// Compares the byte address against the SRAM and control ranges and
// returns the target index with the offset from the matched base.
// Unmatched addresses select the error target.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_decoder import croc_bus_pkg::*; (
  input  addr_t       addr_i,
  output target_idx_t target_o,
  output addr_t       offset_o
);

  logic sram_hit;
  logic ctrl_hit;

  assign sram_hit = (addr_i >= SramBaseAddr) &&
                    (addr_i < (SramBaseAddr + SramSizeBytes));
  assign ctrl_hit = (addr_i >= CtrlBaseAddr) &&
                    (addr_i < (CtrlBaseAddr + CtrlSizeBytes));

  always_comb begin
    target_o = TargetError;
    // Error target sees the raw address
    offset_o = addr_i;
    if (sram_hit) begin
      target_o = TargetSram;
      offset_o = addr_i - SramBaseAddr;
    end else if (ctrl_hit) begin
      target_o = TargetCtrl;
      offset_o = addr_i - CtrlBaseAddr;
    end
  end

endmodule

`default_nettype wire

//--- hw/bus_cut.sv
// ------------------------------------------------------------------------
// Register cut between the decoder and the targets.
// Adds exactly one cycle. There is no back-pressure, so the stage takes
// a new request every cycle. Payload holds its value while req_i is low.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_cut import croc_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic        req_i,
  input  logic        we_i,
  input  strb_t       be_i,
  input  data_t       wdata_i,
  input  addr_t       offset_i,
  input  target_idx_t target_i,

  output logic        req_o,
  output logic        we_o,
  output strb_t       be_o,
  output data_t       wdata_o,
  output addr_t       offset_o,
  output target_idx_t target_o
);

  // Request strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_o <= 1'b0;
    end else begin
      req_o <= req_i;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      we_o     <= we_i;
      be_o     <= be_i;
      wdata_o  <= wdata_i;
      offset_o <= offset_i;
      target_o <= target_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/sram_bank.sv
// ------------------------------------------------------------------------
// Single-port SRAM bank, 512 words of 32 bits.
// Word addressed. Writes honour byte enables. Read data is registered
// on every enabled cycle, so a write returns the old word.
// Contents are undefined after power-up.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sram_bank import croc_bus_pkg::*; (
  input  logic       clk_i,
  input  logic       en_i,
  input  logic       we_i,
  input  strb_t      be_i,
  input  sram_addr_t addr_i,
  input  data_t      wdata_i,
  output data_t      rdata_o
);

  data_t mem_q [SramNumWords];

  // Byte-masked write port
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data, one cycle after enable
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- hw/soc_ctrl_regs.sv
// ------------------------------------------------------------------------
// SoC control registers: fetch enable (bit 0) and boot address.
// Writes are full word, byte enables are not used. Unknown offsets read
// as zero. A write shows on the outputs one cycle after en_i.
// fetch_enable_o also follows fetch_en_i without a register.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_regs import croc_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic        en_i,
  input  logic        we_i,
  input  ctrl_off_t   offset_i,
  input  logic [31:0] wdata_i,
  input  logic        fetch_en_i,

  output logic [31:0] rdata_o,
  output logic        fetch_enable_o,
  output logic [31:0] boot_addr_o
);

  logic        fetch_en_q;
  logic [31:0] boot_addr_q;
  logic [31:0] rdata_d;

  // ------------------------------------------------------------------------
  // Register write
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q  <= 1'b0;
      boot_addr_q <= BootAddrReset;
    end else if (en_i && we_i) begin
      if (offset_i == CtrlFetchEnOff) begin
        fetch_en_q <= wdata_i[0];
      end
      if (offset_i == CtrlBootAddrOff) begin
        boot_addr_q <= wdata_i;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    case (offset_i)
      CtrlFetchEnOff:  rdata_d = {31'b0, fetch_en_q};
      CtrlBootAddrOff: rdata_d = boot_addr_q;
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_o <= rdata_d;
    end
  end

  // External pin can force fetching on
  assign fetch_enable_o = fetch_en_q | fetch_en_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

//--- hw/bus_responder.sv
// ------------------------------------------------------------------------
// Error subordinate and response merge.
// Tracks the target of each cut request for one cycle and forms a single
// response stream. Reads return target data, writes return zero.
// Any access to the error target returns ErrRspData with err set.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_responder import croc_bus_pkg::*, croc_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic        req_i,
  input  logic        we_i,
  input  target_idx_t target_i,
  input  data_t       sram_rdata_i,
  input  data_t       ctrl_rdata_i,

  output logic        rvalid_o,
  output data_t       rdata_o,
  output logic        err_o
);

  logic        rvalid_q;
  logic        we_q;
  target_idx_t target_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      we_q     <= we_i;
      target_q <= target_i;
    end
  end

  // ------------------------------------------------------------------------
  // Response merge
  // ------------------------------------------------------------------------
  always_comb begin
    case (target_q)
      TargetSram: rdata_o = we_q ? '0 : sram_rdata_i;
      TargetCtrl: rdata_o = we_q ? '0 : ctrl_rdata_i;
      // Error subordinate, same answer for reads and writes
      default:    rdata_o = ErrRspData;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (target_q == TargetError);

  // Code 3 would fall into the error branch without err set
  assert property (@(posedge clk_i) disable iff (rst_i)
                   req_i |-> (target_i != 2'b11))
    else $error("cut request carries the unused target code");

endmodule

`default_nettype wire

//--- hw/bus_domain.sv
// ------------------------------------------------------------------------
// Bus domain top: decoder, register cut, SRAM, control registers and
// responder. One manager port, no grant. Every request gets one response
// exactly ReadLatency cycles later, in request order.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_domain import croc_bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  fetch_en_i,

  input  logic  req_i,
  input  logic  we_i,
  input  strb_t be_i,
  input  addr_t addr_i,
  input  data_t wdata_i,

  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o,

  output logic  fetch_enable_o,
  output addr_t boot_addr_o
);

  target_idx_t dec_target;
  addr_t       dec_offset;

  logic        cut_req;
  logic        cut_we;
  strb_t       cut_be;
  data_t       cut_wdata;
  addr_t       cut_offset;
  target_idx_t cut_target;

  logic        sram_en;
  logic        ctrl_en;
  data_t       sram_rdata;
  data_t       ctrl_rdata;

  // ------------------------------------------------------------------------
  // Decode and cut
  // ------------------------------------------------------------------------
  bus_decoder i_bus_decoder (
    .addr_i   ( addr_i     ),
    .target_o ( dec_target ),
    .offset_o ( dec_offset )
  );

  bus_cut i_bus_cut (
    .clk_i,
    .rst_i,
    .req_i    ( req_i      ),
    .we_i     ( we_i       ),
    .be_i     ( be_i       ),
    .wdata_i  ( wdata_i    ),
    .offset_i ( dec_offset ),
    .target_i ( dec_target ),
    .req_o    ( cut_req    ),
    .we_o     ( cut_we     ),
    .be_o     ( cut_be     ),
    .wdata_o  ( cut_wdata  ),
    .offset_o ( cut_offset ),
    .target_o ( cut_target )
  );

  assign sram_en = cut_req && (cut_target == TargetSram);
  assign ctrl_en = cut_req && (cut_target == TargetCtrl);

  // ------------------------------------------------------------------------
  // Targets and response
  // ------------------------------------------------------------------------
  sram_bank i_sram_bank (
    .clk_i,
    .en_i    ( sram_en          ),
    .we_i    ( cut_we           ),
    .be_i    ( cut_be           ),
    .addr_i  ( cut_offset[10:2] ),
    .wdata_i ( cut_wdata        ),
    .rdata_o ( sram_rdata       )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i,
    .rst_i,
    .en_i           ( ctrl_en          ),
    .we_i           ( cut_we           ),
    .offset_i       ( cut_offset[11:0] ),
    .wdata_i        ( cut_wdata        ),
    .fetch_en_i     ( fetch_en_i       ),
    .rdata_o        ( ctrl_rdata       ),
    .fetch_enable_o ( fetch_enable_o   ),
    .boot_addr_o    ( boot_addr_o      )
  );

  bus_responder i_bus_responder (
    .clk_i,
    .rst_i,
    .req_i        ( cut_req    ),
    .we_i         ( cut_we     ),
    .target_i     ( cut_target ),
    .sram_rdata_i ( sram_rdata ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

endmodule

`default_nettype wire

//--- dv/tb_bus_domain.sv
// ------------------------------------------------------------------------
// Testbench for the bus domain top level.
// Keeps a reference copy of SRAM and control registers and a queue of
// expected responses. SRAM words are only read after a full-word write.
// ------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_bus_domain import croc_bus_pkg::*, croc_ctrl_pkg::*; ();

  localparam int ClkPeriod = 8;
  localparam int NumTests  = 5;
  localparam int MaxReqs   = 48;
  localparam int Timeout   = (NumTests * MaxReqs * ReadLatency + 100) * ClkPeriod;

  logic  clk_i = 1'b0;
  logic  rst_i, fetch_en_i, req_i, we_i;
  strb_t be_i;
  addr_t addr_i;
  data_t wdata_i;
  logic  rvalid_o, err_o, fetch_enable_o;
  data_t rdata_o;
  addr_t boot_addr_o;

  bus_domain i_bus_domain (.*);

  // Reference model and expected responses
  data_t      sram_m [SramNumWords];
  logic       fetch_en_m;
  addr_t      boot_m;
  sram_addr_t written_q[$];
  data_t      exp_data_q[$];
  logic       exp_err_q[$];
  int         exp_due_q[$];
  logic       exp_v = 1'b0;
  data_t      exp_d = '0;
  logic       exp_e = 1'b0;

  int         cycle = 0;
  logic [31:0] seed = 32'd9384;
  string      test_name = "reset";
  int         test_errs = 0;
  int         total_errs = 0;
  int         tests_done = 0;

  initial begin
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // ------------------------------------------------------------------------
  // Response checking
  // ------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (exp_due_q.size() > 0 && exp_due_q[0] < cycle) begin
      void'(exp_data_q.pop_front());
      void'(exp_err_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    exp_v = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle);
    exp_d = exp_v ? exp_data_q[0] : '0;
    exp_e = exp_v ? exp_err_q[0] : 1'b0;
  end

  assert property (@(posedge clk_i) disable iff (rst_i) rvalid_o == exp_v)
    else begin
      $display("ERR %s rvalid expected %0b actual %0b", test_name,
               $sampled(exp_v), $sampled(rvalid_o));
      test_errs++;
    end

  assert property (@(posedge clk_i) disable iff (rst_i) rvalid_o |-> rdata_o == exp_d)
    else begin
      $display("ERR %s rdata expected %h actual %h", test_name,
               $sampled(exp_d), $sampled(rdata_o));
      test_errs++;
    end

  assert property (@(posedge clk_i) disable iff (rst_i) rvalid_o |-> err_o == exp_e)
    else begin
      $display("ERR %s err expected %0b actual %0b", test_name,
               $sampled(exp_e), $sampled(err_o));
      test_errs++;
    end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else begin
        $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
        test_errs++;
      end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic issue(input logic we, input addr_t addr, input strb_t be, input data_t wdata);
    data_t      rsp;
    logic       rsp_err;
    sram_addr_t idx;
    ctrl_off_t  off;
    rsp     = '0;
    rsp_err = 1'b0;
    if (addr >= SramBaseAddr && addr < SramBaseAddr + SramSizeBytes) begin
      idx = sram_addr_t'((addr - SramBaseAddr) >> 2);
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) sram_m[idx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end else begin
        rsp = sram_m[idx];
      end
    end else if (addr >= CtrlBaseAddr && addr < CtrlBaseAddr + CtrlSizeBytes) begin
      off = ctrl_off_t'(addr - CtrlBaseAddr);
      if (we) begin
        if (off == CtrlFetchEnOff) fetch_en_m = wdata[0];
        if (off == CtrlBootAddrOff) boot_m = wdata;
      end else if (off == CtrlFetchEnOff) begin
        rsp = {31'b0, fetch_en_m};
      end else if (off == CtrlBootAddrOff) begin
        rsp = boot_m;
      end
    end else begin
      rsp     = ErrRspData;
      rsp_err = 1'b1;
    end
    // Driven in this cycle, rvalid high ReadLatency cycles later
    exp_data_q.push_back(rsp);
    exp_err_q.push_back(rsp_err);
    exp_due_q.push_back(cycle + ReadLatency);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_due_q.size() > 0) @(posedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test();
    $display("Test %-10s done, %0d errors", test_name, test_errs);
    total_errs += test_errs;
    test_errs = 0;
    tests_done++;
  endtask

  function automatic addr_t sram_word(input sram_addr_t idx);
    return SramBaseAddr + {idx, 2'b00};
  endfunction

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    sram_addr_t  idx;
    addr_t       bad;
    logic [31:0] rnd;
    rst_i      = 1'b1;
    fetch_en_i = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    be_i       = '0;
    addr_i     = '0;
    wdata_i    = '0;
    fetch_en_m = 1'b0;
    boot_m     = BootAddrReset;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    check_value("rvalid", 0, 32'(rvalid_o));
    check_value("err", 0, 32'(err_o));
    check_value("boot_addr", BootAddrReset, boot_addr_o);
    fetch_en_i = 1'b1;
    #1;
    check_value("fetch_enable", 1, 32'(fetch_enable_o));
    fetch_en_i = 1'b0;
    #1;
    check_value("fetch_enable", 0, 32'(fetch_enable_o));
    finish_test();

    test_name = "sram_rw";
    for (int i = 0; i < 12; i++) begin
      idx = sram_addr_t'(next_rand() >> 7);
      written_q.push_back(idx);
      issue(1'b1, sram_word(idx), 4'hf, next_rand());
      issue(1'b1, sram_word(idx), strb_t'(next_rand() >> 11), next_rand());
      issue(1'b0, sram_word(idx), 4'h0, '0);
    end
    drain();
    finish_test();

    test_name = "back2back";
    for (int i = 0; i < 40; i++) begin
      idx = written_q[(next_rand() >> 9) % written_q.size()];
      rnd = next_rand();
      issue(rnd[31], sram_word(idx), strb_t'(next_rand() >> 5), next_rand());
    end
    drain();
    finish_test();

    test_name = "ctrl";
    issue(1'b1, CtrlBaseAddr + 32'(CtrlBootAddrOff), 4'hf, 32'h1000_0400);
    check_value("boot_addr", BootAddrReset, boot_addr_o);
    @(posedge clk_i);
    #1;
    check_value("boot_addr", 32'h1000_0400, boot_addr_o);
    issue(1'b0, CtrlBaseAddr + 32'(CtrlBootAddrOff), 4'h0, '0);
    issue(1'b1, CtrlBaseAddr + 32'(CtrlFetchEnOff), 4'hf, 32'h1);
    @(posedge clk_i);
    #1;
    check_value("fetch_enable", 1, 32'(fetch_enable_o));
    issue(1'b0, CtrlBaseAddr + 32'(CtrlFetchEnOff), 4'h0, '0);
    drain();
    check_value("fetch_enable", 1, 32'(fetch_enable_o));
    finish_test();

    test_name = "unmapped";
    for (int i = 0; i < 8; i++) begin
      rnd = next_rand();
      bad = 32'h2000_0000 | {14'b0, rnd[15:0], 2'b00};
      issue(i[0], bad, 4'hf, next_rand());
    end
    issue(1'b0, sram_word(written_q[0]), 4'h0, '0);
    issue(1'b0, CtrlBaseAddr + 32'(CtrlBootAddrOff), 4'h0, '0);
    issue(1'b0, CtrlBaseAddr + 32'(CtrlFetchEnOff), 4'h0, '0);
    drain();
    finish_test();

    $display("Tests run %0d, errors %0d", tests_done, total_errs);
    if (total_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(Timeout);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hw/croc_bus_pkg.sv
hw/croc_ctrl_pkg.sv
hw/bus_decoder.sv
hw/bus_cut.sv
hw/sram_bank.sv
hw/soc_ctrl_regs.sv
hw/bus_responder.sv
hw/bus_domain.sv
dv/tb_bus_domain.sv

//--- Makefile
# Verilator build and run of the bus domain testbench

TOP := tb_bus_domain
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/V$(TOP): project.f $(shell cat project.f)
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
